//--- sim.f
design/axi2wb_pkg.sv
design/sync_fifo.sv
design/burst_decode.sv
design/wb_issue.sv
design/resp_return.sv
design/axi_wr2wb_bridge.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- Makefile
.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -sv -f sim.f --top-module tb_top -o Vtb_top
	./obj_dir/Vtb_top | tee /dev/stderr | grep -qx "TB PASSED"

lint:
	verilator --lint-only --timing -sv -f sim.f --top-module tb_top

clean:
	rm -rf obj_dir

//--- verif/tb_top.sv
// Testbench top; random AXI bursts against a Wishbone slave that errors on word addresses ending 5'h1f
`default_nettype none

module tb_top;
	timeunit 1ns;
	timeprecision 1ps;
	import axi2wb_pkg::*;

	localparam int		NBURST      = 200;
	localparam logic [4:0]	ERR_LOW     = 5'h1f;	// Slave errors on these word addresses
	localparam int		WATCHDOG_NS = NBURST * 8 * 40 * 10;

	logic			clk, rstn;
	logic			awvalid, awready, wvalid, wready, wlast;
	logic [ID_W-1:0]	awid, bid;
	logic [ADDR_W-1:0]	awaddr;
	logic [7:0]		awlen;
	logic [1:0]		awburst, bresp;
	logic [DATA_W-1:0]	wdata, wb_data;
	logic [SEL_W-1:0]	wstrb, wb_sel;
	logic			bvalid, bready;
	logic			wb_cyc, wb_stb, wb_ack, wb_stall, wb_err;
	logic [WB_AW-1:0]	wb_addr;
	logic			end_run;
	int			chk_errors, b_count;

	logic [31:0]		rng_state = 32'd4389;
	int			due_q[$];	// Ack cycle of each accepted request
	bit			err_q[$];
	int			cycle_n, last_due, due;

	function automatic logic [31:0] xorshift32();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	axi_wr2wb_bridge #(.LGFIFO(3), .OPT_SWAP_ENDIAN(1'b1)) i_dut (
		.S_AXI_ACLK(clk), .S_AXI_ARESETN(rstn),
		.i_awvalid(awvalid), .o_awready(awready), .i_awid(awid), .i_awaddr(awaddr),
		.i_awlen(awlen), .i_awburst(awburst),
		.i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata), .i_wstrb(wstrb),
		.i_wlast(wlast),
		.o_bvalid(bvalid), .i_bready(bready), .o_bid(bid), .o_bresp(bresp),
		.o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_addr(wb_addr), .o_wb_data(wb_data),
		.o_wb_sel(wb_sel), .i_wb_ack(wb_ack), .i_wb_stall(wb_stall), .i_wb_err(wb_err));

	tb_checker #(.NBURST(NBURST), .ERR_LOW(ERR_LOW), .SWAP(1'b1)) u_chk (
		.S_AXI_ACLK(clk), .S_AXI_ARESETN(rstn),
		.i_awvalid(awvalid), .i_awready(awready), .i_awid(awid), .i_awaddr(awaddr),
		.i_awlen(awlen), .i_awburst(awburst),
		.i_wvalid(wvalid), .i_wready(wready), .i_wdata(wdata), .i_wstrb(wstrb),
		.i_bvalid(bvalid), .i_bready(bready), .i_bid(bid), .i_bresp(bresp),
		.i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_addr(wb_addr), .i_wb_data(wb_data),
		.i_wb_sel(wb_sel), .i_wb_stall(wb_stall), .i_wb_err(wb_err),
		.i_end_run(end_run), .o_errors(chk_errors), .o_bcount(b_count));

	////////////////////////////////////////
	// AXI write master
	////////////////////////////////////////
	task automatic send_burst();
		logic [31:0]	r, r2;
		logic [7:0]	len;
		logic [1:0]	bt;
		int		gap;
		r   = xorshift32();
		r2  = xorshift32();
		bt  = r[1:0] % 2'd3;
		if (bt == 2'd2)
			len = (8'd2 << (r[3:2] % 2'd3)) - 8'd1;	// 2, 4 or 8 beats
		else
			len = {5'd0, r[6:4]};
		awvalid = 1'b1;
		awid    = r[11:8];
		awaddr  = {r2[15:2], 2'b00};
		awlen   = len;
		awburst = bt;
		do
			@(posedge clk);
		while (!awready);
		@(negedge clk);
		awvalid = 1'b0;
		for (int i = 0; i <= int'(len); i++)
		begin
			gap = int'(xorshift32() % 32'd3);
			if (gap > 0)
			begin
				wvalid = 1'b0;
				repeat (gap) @(negedge clk);
			end
			r      = xorshift32();
			wvalid = 1'b1;
			wdata  = xorshift32();
			wstrb  = r[3:0];
			wlast  = (i == int'(len));
			do
				@(posedge clk);
			while (!wready);
			@(negedge clk);
		end
		wvalid = 1'b0;
		wlast  = 1'b0;
	endtask

	initial
	begin
		rstn    = 1'b0;
		awvalid = 1'b0;
		awid    = '0;
		awaddr  = '0;
		awlen   = '0;
		awburst = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wlast   = 1'b0;
		bready  = 1'b0;
		wb_ack  = 1'b0;
		wb_err  = 1'b0;
		wb_stall = 1'b0;
		end_run = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		for (int n = 0; n < NBURST; n++)
			send_burst();
		wait (b_count == NBURST);
		repeat (5) @(negedge clk);
		end_run = 1'b1;
		#1;
		if (chk_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	////////////////////////////////////////
	// Wishbone slave model
	////////////////////////////////////////
	always @(posedge clk)
	begin
		if (!rstn)
		begin
			due_q.delete();
			err_q.delete();
			cycle_n  = 0;
			last_due = 0;
		end
		else
		begin
			cycle_n++;
			if (!wb_cyc)
			begin
				due_q.delete();	// Dropped cycle abandons pending answers
				err_q.delete();
			end
			else
			begin
				if ((wb_ack || wb_err) && due_q.size() > 0)
				begin
					void'(due_q.pop_front());
					void'(err_q.pop_front());
				end
				if (wb_stb && !wb_stall)
				begin
					due = cycle_n + int'(xorshift32() % 32'd3);
					if (due < last_due)
						due = last_due;	// Keep answers in order
					last_due = due;
					due_q.push_back(due);
					err_q.push_back(wb_addr[4:0] == ERR_LOW);
				end
			end
		end
	end

	always @(negedge clk)
	begin
		wb_ack = 1'b0;
		wb_err = 1'b0;
		if (!rstn)
		begin
			wb_stall = 1'b0;
			bready   = 1'b0;
		end
		else
		begin
			wb_stall = (xorshift32() % 32'd4) == 32'd0;
			bready   = xorshift32() % 32'd2 == 32'd0;
			if (wb_cyc && due_q.size() > 0 && due_q[0] <= cycle_n)
			begin
				if (err_q[0])
					wb_err = 1'b1;
				else
					wb_ack = 1'b1;
			end
		end
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the bursts did not all finish in time");
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/tb_checker.sv
// Bridge scoreboard; one Wishbone burst at a time, all ports sampled on the rising edge
`default_nettype none

module tb_checker #(
	parameter int		NBURST  = 200,
	parameter logic [4:0]	ERR_LOW = 5'h1f,
	parameter bit		SWAP    = 1'b1
) (
	input  logic				S_AXI_ACLK,
	input  logic				S_AXI_ARESETN,
	input  logic				i_awvalid,
	input  logic				i_awready,
	input  logic [axi2wb_pkg::ID_W-1:0]	i_awid,
	input  logic [axi2wb_pkg::ADDR_W-1:0]	i_awaddr,
	input  logic [7:0]			i_awlen,
	input  logic [1:0]			i_awburst,
	input  logic				i_wvalid,
	input  logic				i_wready,
	input  logic [axi2wb_pkg::DATA_W-1:0]	i_wdata,
	input  logic [axi2wb_pkg::SEL_W-1:0]	i_wstrb,
	input  logic				i_bvalid,
	input  logic				i_bready,
	input  logic [axi2wb_pkg::ID_W-1:0]	i_bid,
	input  logic [1:0]			i_bresp,
	input  logic				i_wb_cyc,
	input  logic				i_wb_stb,
	input  logic [axi2wb_pkg::WB_AW-1:0]	i_wb_addr,
	input  logic [axi2wb_pkg::DATA_W-1:0]	i_wb_data,
	input  logic [axi2wb_pkg::SEL_W-1:0]	i_wb_sel,
	input  logic				i_wb_stall,
	input  logic				i_wb_err,
	input  logic				i_end_run,
	output int				o_errors,
	output int				o_bcount
);
	timeunit 1ns;
	timeprecision 1ps;
	import axi2wb_pkg::*;

	// Per burst
	int			bid_exp[NBURST], blen[NBURST], bstart[NBURST], errbeat[NBURST];
	int			issued[NBURST];
	logic [1:0]		btype[NBURST];
	// Per predicted beat
	logic [WB_AW-1:0]	eaddr[NBURST*8];
	logic [DATA_W-1:0]	edata[NBURST*8];
	logic [SEL_W-1:0]	esel[NBURST*8];
	int			aw_n, beat_n, b_n, wcnt, cur, bi;
	logic [WB_AW-1:0]	addr_cur;
	bit			err_seen, err_prev, reset_checked;
	int			errs[1:5];
	string			names[1:5];

	initial
	begin
		names[1] = "INCR beat address, data and select";
		names[2] = "FIXED and WRAP addresses";
		names[3] = "B order, ID and OKAY";
		names[4] = "error bursts";
		names[5] = "back-pressure and reset";
		for (int k = 1; k <= 5; k++)
			errs[k] = 0;
		aw_n = 0;
		beat_n = 0;
		b_n = 0;
		cur = -1;
		bi = 0;
		err_seen = 1'b0;
		err_prev = 1'b0;
		reset_checked = 1'b0;
	end

	assign o_bcount = b_n;

	function automatic logic [WB_AW-1:0] next_word(input logic [WB_AW-1:0] a,
			input logic [1:0] bt, input int beats);
		int base;
		base = (int'(a) / beats) * beats;	// Window aligned to its size
		case (bt)
		2'd0:		return a;
		2'd2:		return WB_AW'(base + (int'(a) - base + 1) % beats);
		default:	return a + 1'b1;
		endcase
	endfunction

	function automatic logic [DATA_W-1:0] lane_data(input logic [DATA_W-1:0] d);
		return SWAP ? {d[7:0], d[15:8], d[23:16], d[31:24]} : d;
	endfunction

	function automatic logic [SEL_W-1:0] lane_sel(input logic [SEL_W-1:0] s);
		return SWAP ? {s[0], s[1], s[2], s[3]} : s;
	endfunction

	task automatic value_fail(input int beh, input string name, input logic [31:0] exp,
			input logic [31:0] got);
		$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
		errs[beh]++;
	endtask

	task automatic note_fail(input int beh, input string msg);
		$display("Error at %0t: %s", $time, msg);
		errs[beh]++;
	endtask

	always @(posedge S_AXI_ACLK)
	begin
		if (S_AXI_ARESETN && !reset_checked)
		begin
			reset_checked = 1'b1;
			if ((i_wb_cyc | i_wb_stb | i_bvalid) !== 1'b0)
				note_fail(5, "cyc, stb or BVALID high right after reset");
		end
		if (S_AXI_ARESETN)
		begin
			if (i_awvalid && i_awready)
			begin
				bid_exp[aw_n] = int'(i_awid);
				blen[aw_n]    = int'(i_awlen) + 1;
				btype[aw_n]   = i_awburst;
				bstart[aw_n]  = beat_n;
				errbeat[aw_n] = -1;
				issued[aw_n]  = 0;
				addr_cur      = i_awaddr[ADDR_W-1:2];
				wcnt          = 0;
				aw_n++;
			end
			if (i_wvalid && i_wready)
			begin
				eaddr[beat_n] = addr_cur;
				edata[beat_n] = lane_data(i_wdata);
				esel[beat_n]  = lane_sel(i_wstrb);
				if (errbeat[aw_n-1] < 0 && addr_cur[4:0] == ERR_LOW)
					errbeat[aw_n-1] = wcnt;
				wcnt++;
				addr_cur = next_word(addr_cur, btype[aw_n-1], blen[aw_n-1]);
				beat_n++;
			end
			// Cycle must close right after an error
			if (err_prev && (i_wb_cyc || i_wb_stb))
				note_fail(4, "Wishbone cycle still open after an error");
			err_prev = i_wb_cyc && i_wb_err;
			// Wishbone request accepted
			if (i_wb_cyc && i_wb_stb && !i_wb_stall)
			begin
				if (cur < 0 || err_seen || bi >= blen[cur])
				begin
					cur++;
					bi = 0;
					err_seen = 1'b0;
				end
				if (cur >= aw_n || bstart[cur] + bi >= beat_n)
					note_fail(5, "Wishbone request with no matching W beat");
				else
				begin
					if (eaddr[bstart[cur]+bi] != i_wb_addr)
						value_fail((btype[cur] == 2'd1) ? 1 : 2, "o_wb_addr",
							32'(eaddr[bstart[cur]+bi]), 32'(i_wb_addr));
					if (edata[bstart[cur]+bi] != i_wb_data)
						value_fail(1, "o_wb_data", edata[bstart[cur]+bi], i_wb_data);
					if (esel[bstart[cur]+bi] != i_wb_sel)
						value_fail(1, "o_wb_sel", 32'(esel[bstart[cur]+bi]),
							32'(i_wb_sel));
					issued[cur]++;
					bi++;
				end
			end
			if (i_wb_cyc && i_wb_err)
				err_seen = 1'b1;	// Later requests must belong to the next burst
			if (i_bvalid && i_bready)
			begin
				if (b_n >= aw_n)
					note_fail(3, "B response with no accepted burst");
				else
				begin
					if (int'(i_bid) != bid_exp[b_n])
						value_fail(3, "o_bid", 32'(bid_exp[b_n]), 32'(i_bid));
					if (errbeat[b_n] >= 0)
					begin
						if (i_bresp != RESP_SLVERR)
							value_fail(4, "o_bresp", 32'(RESP_SLVERR), 32'(i_bresp));
						if (issued[b_n] < errbeat[b_n] + 1)
							note_fail(4, "error burst stopped before its error beat");
					end
					else
					begin
						if (i_bresp != RESP_OKAY)
							value_fail(3, "o_bresp", 32'(RESP_OKAY), 32'(i_bresp));
						if (issued[b_n] != blen[b_n])
							note_fail(5, "beats lost or duplicated in a burst");
					end
				end
				b_n++;
			end
		end
	end

	////////////////////////////////////////
	// Summary
	////////////////////////////////////////
	always @(posedge i_end_run)
	begin
		if (b_n != NBURST)
			note_fail(5, "B handshake count differs from the burst count");
		o_errors = 0;
		for (int k = 1; k <= 5; k++)
		begin
			$display("Behavior %0d, %s: %s", k, names[k],
				(errs[k] == 0) ? "ok" : "failed");
			o_errors += errs[k];
		end
		$display("Checked %0d bursts and %0d beats, %0d errors", b_n, beat_n, o_errors);
	end

endmodule

`default_nettype wire

//--- design/axi_wr2wb_bridge.sv
// AXI4 write to Wishbone pipelined bridge; no read channels, AWSIZE must equal the bus width
`default_nettype none

module axi_wr2wb_bridge #(
	parameter int LGFIFO          = 3,
	parameter bit OPT_SWAP_ENDIAN = 1'b1
) (
	input  logic				S_AXI_ACLK,
	input  logic				S_AXI_ARESETN,
	// AW
	input  logic				i_awvalid,
	output logic				o_awready,
	input  logic [axi2wb_pkg::ID_W-1:0]	i_awid,
	input  logic [axi2wb_pkg::ADDR_W-1:0]	i_awaddr,
	input  logic [7:0]			i_awlen,
	input  logic [1:0]			i_awburst,
	// W
	input  logic				i_wvalid,
	output logic				o_wready,
	input  logic [axi2wb_pkg::DATA_W-1:0]	i_wdata,
	input  logic [axi2wb_pkg::SEL_W-1:0]	i_wstrb,
	input  logic				i_wlast,
	// B
	output logic				o_bvalid,
	input  logic				i_bready,
	output logic [axi2wb_pkg::ID_W-1:0]	o_bid,
	output logic [1:0]			o_bresp,
	// Wishbone
	output logic				o_wb_cyc,
	output logic				o_wb_stb,
	output logic [axi2wb_pkg::WB_AW-1:0]	o_wb_addr,
	output logic [axi2wb_pkg::DATA_W-1:0]	o_wb_data,
	output logic [axi2wb_pkg::SEL_W-1:0]	o_wb_sel,
	input  logic				i_wb_ack,
	input  logic				i_wb_stall,
	input  logic				i_wb_err
);
	import axi2wb_pkg::*;

	aw_req_t		aw;
	beat_t			beat;
	logic			beat_valid, beat_ready;
	logic			id_push, resp_full, done;
	logic [ID_W-1:0]	id;
	burst_done_t		done_info;

	assign aw = '{id: i_awid, addr: i_awaddr, len: i_awlen, burst: burst_t'(i_awburst)};

	burst_decode u_decode (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_aw_valid(i_awvalid), .i_aw(aw), .o_aw_ready(o_awready),
		.i_w_valid(i_wvalid), .i_w_data(i_wdata), .i_w_strb(i_wstrb),
		.i_w_last(i_wlast), .o_w_ready(o_wready),
		.o_beat_valid(beat_valid), .o_beat(beat), .i_beat_ready(beat_ready),
		.o_id_push(id_push), .o_id(id), .i_resp_full(resp_full));

	wb_issue #(.OPT_SWAP_ENDIAN(OPT_SWAP_ENDIAN)) u_issue (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_beat_valid(beat_valid), .i_beat(beat), .o_beat_ready(beat_ready),
		.o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_addr(o_wb_addr),
		.o_wb_data(o_wb_data), .o_wb_sel(o_wb_sel),
		.i_wb_ack(i_wb_ack), .i_wb_stall(i_wb_stall), .i_wb_err(i_wb_err),
		.o_done(done), .o_done_info(done_info));

	resp_return #(.LGFIFO(LGFIFO)) u_return (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_id_push(id_push), .i_id(id),
		.i_done(done), .i_done_info(done_info), .o_full(resp_full),
		.i_bready(i_bready), .o_bvalid(o_bvalid),
		.o_bid(o_bid), .o_bresp(o_bresp));

endmodule

`default_nettype wire

//--- design/resp_return.sv
// B channel return; responses leave in AW order, queue depth is 2^LGFIFO bursts
`default_nettype none

module resp_return #(
	parameter int LGFIFO = 3
) (
	input  logic				S_AXI_ACLK,
	input  logic				S_AXI_ARESETN,
	input  logic				i_id_push,
	input  logic [axi2wb_pkg::ID_W-1:0]	i_id,
	input  logic				i_done,
	input  axi2wb_pkg::burst_done_t		i_done_info,
	output logic				o_full,
	// AXI write response
	input  logic				i_bready,
	output logic				o_bvalid,
	output logic [axi2wb_pkg::ID_W-1:0]	o_bid,
	output axi2wb_pkg::resp_t		o_bresp
);
	import axi2wb_pkg::*;

	localparam int RW = $bits(burst_done_t);

	logic		id_empty, res_empty, b_fire;
	burst_done_t	res_head;
	logic [LGFIFO:0]	occ_q;	// Pending plus unanswered bursts
	logic [LGFIFO:0]	res_q;	// Results waiting for B

	sync_fifo #(.WIDTH(ID_W), .LGDEPTH(LGFIFO)) u_id_fifo (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_push(i_id_push), .i_data(i_id), .i_pop(b_fire),
		.o_data(o_bid), .o_empty(id_empty), .o_full());

	sync_fifo #(.WIDTH(RW), .LGDEPTH(LGFIFO)) u_res_fifo (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_push(i_done), .i_data(i_done_info), .i_pop(b_fire),
		.o_data(res_head), .o_empty(res_empty), .o_full());

	assign o_bvalid = !id_empty && !res_empty;
	assign b_fire   = o_bvalid && i_bready;
	assign o_bresp  = res_head.err ? RESP_SLVERR : RESP_OKAY;
	assign o_full   = occ_q[LGFIFO];

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			occ_q <= '0;
			res_q <= '0;
		end
		else
		begin
			occ_q <= occ_q + (LGFIFO+1)'(i_id_push) - (LGFIFO+1)'(b_fire);
			res_q <= res_q + (LGFIFO+1)'(i_done) - (LGFIFO+1)'(b_fire);
		end
	end

	// A result always belongs to an accepted burst
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN) res_q <= occ_q);

endmodule

`default_nettype wire

//--- design/wb_issue.sv
// Wishbone pipelined write master; one burst per cycle, at most 256 requests outstanding
`default_nettype none

module wb_issue #(
	parameter bit OPT_SWAP_ENDIAN = 1'b1
) (
	input  logic				S_AXI_ACLK,
	input  logic				S_AXI_ARESETN,
	input  logic				i_beat_valid,
	input  axi2wb_pkg::beat_t		i_beat,
	output logic				o_beat_ready,
	// Wishbone master
	output logic				o_wb_cyc,
	output logic				o_wb_stb,
	output logic [axi2wb_pkg::WB_AW-1:0]	o_wb_addr,
	output logic [axi2wb_pkg::DATA_W-1:0]	o_wb_data,
	output logic [axi2wb_pkg::SEL_W-1:0]	o_wb_sel,
	input  logic				i_wb_ack,
	input  logic				i_wb_stall,
	input  logic				i_wb_err,
	// Burst result
	output logic				o_done,
	output axi2wb_pkg::burst_done_t		o_done_info
);
	import axi2wb_pkg::*;

	localparam int OW = 9;

	logic			busy_q;		// First beat taken, result not yet given
	logic			last_q;		// Last beat taken
	logic			err_q;
	logic [OW-1:0]		outst_q, outst_nx;
	logic			req_fire, ack_in, err_in, abort;
	logic			beat_fire, issue, finish;
	logic [DATA_W-1:0]	wr_data;
	logic [SEL_W-1:0]	wr_sel;

	assign req_fire = o_wb_stb && !i_wb_stall;
	assign ack_in   = o_wb_cyc && i_wb_ack;
	assign err_in   = o_wb_cyc && i_wb_err;
	assign abort    = err_q || err_in;	// Beats from here on are dropped

	assign o_beat_ready = !busy_q
			|| (!last_q && (abort || !o_wb_stb || !i_wb_stall));
	assign beat_fire = i_beat_valid && o_beat_ready;
	assign issue     = beat_fire && !abort;
	assign outst_nx  = outst_q + OW'(req_fire) - OW'(ack_in);

	always_comb
	begin
		finish = 1'b0;
		if (busy_q && abort)
			finish = last_q || (beat_fire && i_beat.last);
		else if (busy_q)
			finish = last_q && !o_wb_stb && (outst_nx == '0);
	end

	assign o_done      = finish;
	assign o_done_info = '{err: abort};

	////////////////////////////////////////
	// Byte lane order
	////////////////////////////////////////
	generate
		if (OPT_SWAP_ENDIAN)
		begin : g_swap
			always_comb
			begin
				for (int k = 0; k < SEL_W; k++)
				begin
					wr_data[k*8 +: 8] = i_beat.data[(SEL_W-1-k)*8 +: 8];
					wr_sel[k]         = i_beat.sel[SEL_W-1-k];
				end
			end
		end
		else
		begin : g_keep
			assign wr_data = i_beat.data;
			assign wr_sel  = i_beat.sel;
		end
	endgenerate

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || finish)
		begin
			busy_q   <= 1'b0;
			last_q   <= 1'b0;
			err_q    <= 1'b0;
			outst_q  <= '0;
			o_wb_cyc <= 1'b0;
			o_wb_stb <= 1'b0;
		end
		else
		begin
			if (beat_fire && i_beat.first)
				busy_q <= 1'b1;
			if (beat_fire && i_beat.last)
				last_q <= 1'b1;
			if (err_in)
				err_q <= 1'b1;
			if (abort)
			begin
				// Cycle abandoned, pending acks go with it
				o_wb_cyc <= 1'b0;
				o_wb_stb <= 1'b0;
				outst_q  <= '0;
			end
			else
			begin
				outst_q <= outst_nx;
				if (issue)
				begin
					o_wb_cyc <= 1'b1;
					o_wb_stb <= 1'b1;
				end
				else if (req_fire)
					o_wb_stb <= 1'b0;
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (issue)
		begin
			o_wb_addr <= i_beat.wb_addr;
			o_wb_data <= wr_data;
			o_wb_sel  <= wr_sel;
		end
	end

	// Slave answers only requests it has taken
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(i_wb_ack || i_wb_err) |-> (o_wb_cyc && (outst_q != '0)));
	// Stalled request keeps its payload
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(o_wb_stb && i_wb_stall && !abort) |=> (o_wb_stb && $stable(o_wb_addr)
			&& $stable(o_wb_data) && $stable(o_wb_sel)));

endmodule

`default_nettype wire

//--- design/burst_decode.sv
// AW and W join; one burst at a time, WRAP lengths must be 2, 4, 8 or 16 beats
`default_nettype none

module burst_decode (
	input  logic				S_AXI_ACLK,
	input  logic				S_AXI_ARESETN,
	// AXI address and data
	input  logic				i_aw_valid,
	input  axi2wb_pkg::aw_req_t		i_aw,
	output logic				o_aw_ready,
	input  logic				i_w_valid,
	input  logic [axi2wb_pkg::DATA_W-1:0]	i_w_data,
	input  logic [axi2wb_pkg::SEL_W-1:0]	i_w_strb,
	input  logic				i_w_last,
	output logic				o_w_ready,
	// Decoded beats to the issue stage
	output logic				o_beat_valid,
	output axi2wb_pkg::beat_t		o_beat,
	input  logic				i_beat_ready,
	// Burst IDs to the return stage
	output logic				o_id_push,
	output logic [axi2wb_pkg::ID_W-1:0]	o_id,
	input  logic				i_resp_full
);
	import axi2wb_pkg::*;

	logic			active_q;	// AW taken, WLAST not yet seen
	logic			first_q;
	logic [WB_AW-1:0]	addr_q, next_addr;
	logic [WB_AW-1:0]	wrap_mask;
	logic [7:0]		len_q;
	logic [7:0]		cnt_q;		// Beats passed in this burst
	burst_t			burst_q;
	logic			aw_fire, beat_fire;

	assign o_aw_ready = !active_q && !i_resp_full;
	assign aw_fire    = i_aw_valid && o_aw_ready;

	assign o_id_push = aw_fire;
	assign o_id      = i_aw.id;

	// W passes straight through as a beat
	assign o_beat_valid = active_q && i_w_valid;
	assign o_w_ready    = active_q && i_beat_ready;
	assign beat_fire    = o_beat_valid && i_beat_ready;

	assign o_beat = '{wb_addr: addr_q, data: i_w_data, sel: i_w_strb,
			first: first_q, last: i_w_last};

	////////////////////////////////////////
	// Next word address
	////////////////////////////////////////
	assign wrap_mask = {{(WB_AW-8){1'b0}}, len_q};	// len+1 words, aligned

	always_comb
	begin
		case (burst_q)
		BURST_FIXED:	next_addr = addr_q;
		BURST_WRAP:	next_addr = (addr_q & ~wrap_mask)
					| ((addr_q + 1'b1) & wrap_mask);
		default:	next_addr = addr_q + 1'b1;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			active_q <= 1'b0;
			first_q  <= 1'b0;
		end
		else if (aw_fire)
		begin
			active_q <= 1'b1;
			first_q  <= 1'b1;
		end
		else if (beat_fire)
		begin
			first_q <= 1'b0;
			if (i_w_last)
				active_q <= 1'b0;	// Burst closes on WLAST
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (aw_fire)
		begin
			addr_q  <= i_aw.addr[ADDR_W-1:2];	// Byte lanes dropped
			len_q   <= i_aw.len;
			burst_q <= i_aw.burst;
			cnt_q   <= '0;
		end
		else if (beat_fire)
		begin
			addr_q <= next_addr;
			cnt_q  <= cnt_q + 1'b1;
		end
	end

	// Master must end the burst on beat len+1
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		beat_fire |-> (i_w_last == (cnt_q == len_q)));
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_aw_valid |-> (i_aw.burst != 2'b11));

endmodule

`default_nettype wire

//--- design/sync_fifo.sv
// First-word-fall-through FIFO; a push while full is dropped, depth is a power of two
`default_nettype none

module sync_fifo #(
	parameter int WIDTH   = 8,
	parameter int LGDEPTH = 3
) (
	input  logic			S_AXI_ACLK,
	input  logic			S_AXI_ARESETN,
	input  logic			i_push,
	input  logic [WIDTH-1:0]	i_data,
	input  logic			i_pop,
	output logic [WIDTH-1:0]	o_data,
	output logic			o_empty,
	output logic			o_full
);

	logic [WIDTH-1:0]	mem [2**LGDEPTH];
	logic [LGDEPTH:0]	wr_ptr, rd_ptr;	// Extra bit tells full from empty

	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full  = (wr_ptr[LGDEPTH] != rd_ptr[LGDEPTH])
			&& (wr_ptr[LGDEPTH-1:0] == rd_ptr[LGDEPTH-1:0]);
	assign o_data  = mem[rd_ptr[LGDEPTH-1:0]];	// Head shown combinationally

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (i_push && !o_full)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_pop && !o_empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_push && !o_full)
			mem[wr_ptr[LGDEPTH-1:0]] <= i_data;
	end

	// Callers track their own occupancy
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN) i_push |-> !o_full);
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN) i_pop |-> !o_empty);

endmodule

`default_nettype wire

//--- design/axi2wb_pkg.sv
// Shared bridge types; full-width beats only, AWSIZE is not carried and WB_AW must be 8 or more
`default_nettype none

package axi2wb_pkg;

	////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////
	localparam int ID_W   = 4;
	localparam int ADDR_W = 16;		// AXI byte address
	localparam int DATA_W = 32;
	localparam int SEL_W  = DATA_W / 8;
	localparam int WB_AW  = ADDR_W - 2;	// Wishbone word address

	// AXI burst encodings with 2'b11 reserved
	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01,
		BURST_WRAP  = 2'b10
	} burst_t;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_t;

	////////////////////////////////////////
	// Stage payloads
	////////////////////////////////////////
	typedef struct packed {
		logic [ID_W-1:0]	id;
		logic [ADDR_W-1:0]	addr;
		logic [7:0]		len;	// Beats minus one
		burst_t			burst;
	} aw_req_t;

	typedef struct packed {
		logic [WB_AW-1:0]	wb_addr;
		logic [DATA_W-1:0]	data;
		logic [SEL_W-1:0]	sel;
		logic			first;
		logic			last;
	} beat_t;

	// One result per burst
	typedef struct packed {
		logic	err;
	} burst_done_t;

endpackage

`default_nettype wire
